// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = mips_core_tb
FLIST = mips_core.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/alu.sv ====
// integer ALU for the supported subset, with a zero flag for branches.
`timescale 1ns/1ps

module alu (
    input  logic [31:0]       a_i,
    input  logic [31:0]       b_i,
    input  logic [4:0]        shamt_i,
    input  mips_pkg::alu_op_e op_i,
    output logic [31:0]       res_o,
    output logic              zero_o
);
    import mips_pkg::*;

    logic slt;

    assign slt = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            ALU_ADD: res_o = a_i + b_i;
            ALU_SUB: res_o = a_i - b_i;
            ALU_AND: res_o = a_i & b_i;
            ALU_OR:  res_o = a_i | b_i;
            ALU_SLT: res_o = {31'h0, slt};
            ALU_SLL: res_o = b_i << shamt_i;  // shifts rt, as SLL does.
            ALU_LUI: res_o = {b_i[15:0], 16'h0000};
            default: res_o = a_i + b_i;
        endcase
    end

    assign zero_o = (res_o == 32'h0);

endmodule

// ==== design/data_mem.sv ====
// word-addressed data RAM, asynchronous read and write at the clock edge.
`timescale 1ns/1ps

module data_mem (
    input  logic        clk,
    input  logic        we_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o
);
    import mips_pkg::*;

    logic [31:0]        ram [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_addr;

    assign word_addr = addr_i[DMEM_AW+1:2];  // byte offset bits are ignored.

    always_ff @(posedge clk) begin
        if (we_i) begin
            ram[word_addr] <= wdata_i;
        end
    end

    assign rdata_o = ram[word_addr];

endmodule

// ==== design/decode_ctrl.sv ====
// instruction decoder producing the control struct and the extended immediate.
// purely combinational, driven straight from the fetched word.
`timescale 1ns/1ps

module decode_ctrl (
    input  mips_pkg::instr_u instr_i,
    output mips_pkg::ctrl_t  ctrl_o,
    output logic [31:0]      imm_o
);
    import mips_pkg::*;

    logic [15:0] imm_raw;

    assign imm_raw = instr_i.i_fmt.imm;
    assign imm_o   = ctrl_o.sign_ext ? {{16{imm_raw[15]}}, imm_raw} : {16'h0000, imm_raw};

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ALU_ADD;
        case (instr_i.r_fmt.op)
            OP_RTYPE: begin
                ctrl_o.reg_dst = 1'b1;
                ctrl_o.reg_wr  = 1'b1;
                case (instr_i.r_fmt.funct)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl_o.alu_op        = ALU_SLL;
                        ctrl_o.alu_src_shamt = 1'b1;
                    end
                    default: ctrl_o.reg_wr = 1'b0;  // unsupported funct writes nothing.
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.sign_ext    = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
            end
            OP_ORI: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
                ctrl_o.alu_op      = ALU_OR;
            end
            OP_LUI: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
                ctrl_o.alu_op      = ALU_LUI;
            end
            OP_LW: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.sign_ext    = 1'b1;
                ctrl_o.mem_to_reg  = 1'b1;
                ctrl_o.reg_wr      = 1'b1;
            end
            OP_SW: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.sign_ext    = 1'b1;
                ctrl_o.mem_wr      = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.branch    = 1'b1;
                ctrl_o.branch_ne = (instr_i.r_fmt.op == OP_BNE);
                ctrl_o.sign_ext  = 1'b1;
                ctrl_o.alu_op    = ALU_SUB;  // zero flag compares rs with rt.
            end
            OP_J: ctrl_o.jump = 1'b1;
            default: ctrl_o = '0;  // unknown opcode, no write of any kind.
        endcase
    end

endmodule

// ==== design/fetch_unit.sv ====
// program counter with next-PC selection and the instruction RAM.
// the RAM is loaded through the write port while run_i is low.
`timescale 1ns/1ps

module fetch_unit (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         run_i,
    input  logic                         imem_we_i,
    input  logic [mips_pkg::IMEM_AW-1:0] imem_addr_i,
    input  logic [31:0]                  imem_data_i,
    input  logic                         branch_i,
    input  logic                         branch_ne_i,
    input  logic                         jump_i,
    input  logic                         zero_i,
    input  logic [31:0]                  imm_i,
    output logic [31:0]                  pc_o,
    output mips_pkg::instr_u             instr_o
);
    import mips_pkg::*;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] pc_seq;
    logic [31:0] pc_branch;
    logic [31:0] pc_jump;
    logic [31:0] pc_next;
    logic        take_branch;

    always_ff @(posedge clk) begin
        if (imem_we_i && !run_i) begin  // loading is only accepted while stopped.
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    assign instr_o = imem[pc_o[IMEM_AW+1:2]];

    assign pc_seq      = pc_o + 32'd4;
    assign pc_branch   = pc_seq + {imm_i[29:0], 2'b00};
    assign pc_jump     = {pc_seq[31:28], instr_o.j_fmt.target, 2'b00};
    assign take_branch = branch_i & (zero_i ^ branch_ne_i);  // BNE inverts the zero test.

    always_comb begin
        if (jump_i) begin
            pc_next = pc_jump;
        end else if (take_branch) begin
            pc_next = pc_branch;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= '0;
        end else if (run_i) begin
            pc_o <= pc_next;  // holds while the core is paused.
        end
    end

endmodule

// ==== design/mips_core.sv ====
// single-cycle MIPS32 subset core; one instruction retires per clock while run_i is high.
// the retire record shows the register write and store of the instruction at the PC.
`timescale 1ns/1ps

module mips_core (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         run_i,
    input  logic                         imem_we_i,
    input  logic [mips_pkg::IMEM_AW-1:0] imem_addr_i,
    input  logic [31:0]                  imem_data_i,
    output mips_pkg::retire_t            retire_o
);
    import mips_pkg::*;

    instr_u      instr;
    ctrl_t       ctrl;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic [31:0] mem_rdata;
    logic [31:0] wb_data;
    logic [4:0]  wr_reg;
    logic [4:0]  shamt;
    logic        alu_zero;
    logic        rf_we;
    logic        mem_we;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .run_i       (run_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .branch_i    (ctrl.branch),
        .branch_ne_i (ctrl.branch_ne),
        .jump_i      (ctrl.jump),
        .zero_i      (alu_zero),
        .imm_i       (imm),
        .pc_o        (pc),
        .instr_o     (instr)
    );

    decode_ctrl u_decode (
        .instr_i (instr),
        .ctrl_o  (ctrl),
        .imm_o   (imm)
    );

    assign wr_reg  = ctrl.reg_dst ? instr.r_fmt.rd : instr.i_fmt.rt;
    assign rf_we   = ctrl.reg_wr & run_i;  // nothing is written while paused.
    assign mem_we  = ctrl.mem_wr & run_i;
    assign wb_data = ctrl.mem_to_reg ? mem_rdata : alu_res;

    regfile u_regfile (
        .clk       (clk),
        .we_i      (rf_we),
        .waddr_i   (wr_reg),
        .wdata_i   (wb_data),
        .raddr_a_i (instr.r_fmt.rs),
        .raddr_b_i (instr.r_fmt.rt),
        .rdata_a_o (rs_data),
        .rdata_b_o (rt_data)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : rt_data;
    assign shamt = ctrl.alu_src_shamt ? instr.r_fmt.shamt : 5'd0;

    alu u_alu (
        .a_i     (rs_data),
        .b_i     (alu_b),
        .shamt_i (shamt),
        .op_i    (ctrl.alu_op),
        .res_o   (alu_res),
        .zero_o  (alu_zero)
    );

    data_mem u_dmem (
        .clk     (clk),
        .we_i    (mem_we),
        .addr_i  (alu_res),
        .wdata_i (rt_data),
        .rdata_o (mem_rdata)
    );

    always_comb begin
        retire_o.valid    = run_i;
        retire_o.pc       = pc;
        retire_o.rf_we    = rf_we & (wr_reg != 5'd0);  // a write to r0 has no visible effect.
        retire_o.rf_addr  = wr_reg;
        retire_o.rf_data  = wb_data;
        retire_o.mem_we   = mem_we;
        retire_o.mem_addr = alu_res;
        retire_o.mem_data = rt_data;
    end

endmodule

// ==== design/mips_pkg.sv ====
// shared opcodes, instruction formats and records for the single-cycle MIPS32 core.
// compile it ahead of every design file.
package mips_pkg;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_SLL = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic    reg_dst;       // write rd instead of rt.
        logic    alu_src_imm;
        logic    alu_src_shamt;
        logic    sign_ext;
        logic    mem_to_reg;
        logic    mem_wr;
        logic    reg_wr;
        logic    branch;
        logic    branch_ne;     // branch on non-zero, so BNE.
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_addr;
        logic [31:0] rf_data;
        logic        mem_we;
        logic [31:0] mem_addr;
        logic [31:0] mem_data;
    } retire_t;

endpackage

// ==== design/regfile.sv ====
// 32 x 32 register file, two combinational reads and one clocked write.
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr_a_i,
    input  logic [4:0]  raddr_b_i,
    output logic [31:0] rdata_a_o,
    output logic [31:0] rdata_b_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != 5'd0)) begin  // register zero is never written.
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'h0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'h0 : regs[raddr_b_i];

endmodule

// ==== mips_core.f ====
design/mips_pkg.sv
design/fetch_unit.sv
design/decode_ctrl.sv
design/regfile.sv
design/alu.sv
design/data_mem.sv
design/mips_core.sv
sim/mips_core_props.sv
sim/mips_core_tb.sv

// ==== sim/mips_core_props.sv ====
// assertions on the core's pause behavior and retire record.
// bound into every mips_core instance.
`timescale 1ns/1ps

module mips_core_props (
    input logic              clk,
    input logic              reset_i,
    input logic              run_i,
    input mips_pkg::retire_t retire_i
);

    pc_holds_when_stopped: assert property (@(posedge clk) disable iff (reset_i)
        !run_i |=> $stable(retire_i.pc))
        else $error("pc moved after a cycle with run_i low");

    idle_after_reset: assert property (@(posedge clk) $fell(reset_i) |->
        (!retire_i.valid && retire_i.pc == 32'h0))
        else $error("retire record not idle at pc zero in the cycle after reset");

endmodule

bind mips_core mips_core_props u_props (
    .clk      (clk),
    .reset_i  (reset_i),
    .run_i    (run_i),
    .retire_i (retire_o)
);

// ==== sim/mips_core_stim.txt ====
# T test | I word_index(dec) instr(hex) | R reg(dec) data(hex) | S addr(hex) data(hex)
# R and S lines are the expected register writes and stores of each test, in program order.
T 1
I 0 24010005
I 1 2402fffd
I 2 34038f0f
I 3 3c041234
R 1 00000005
R 2 fffffffd
R 3 00008f0f
R 4 12340000
T 2
I 4 00222821
I 5 00413023
I 6 00433824
I 7 00834025
I 8 0041482a
I 9 0026502a
I 10 00016100
R 5 00000002
R 6 fffffff8
R 7 00008f0d
R 8 12348f0f
R 9 00000001
R 10 00000000
R 12 00000050
T 3
I 11 240d0040
I 12 ada4fffc
I 13 8daefffc
R 13 00000040
S 0000003c 12340000
R 14 12340000
T 4
I 14 10220001
I 15 24100001
I 16 14210001
I 17 24110002
I 18 11c40001
I 19 24120099
I 20 14220001
I 21 24130077
I 22 08000018
I 23 24140055
I 24 24150003
R 16 00000001
R 17 00000002
R 21 00000003
T 5
I 25 24001234
I 26 0004b021
I 27 0800001b
R 22 12340000

// ==== sim/mips_core_tb.sv ====
// testbench for the single-cycle MIPS32 core; loads the program from the stim file,
// runs it with random pauses and checks every register write and store in order.
`timescale 1ns/1ps

module mips_core_tb;
    import mips_pkg::*;

    typedef struct packed {
        logic [IMEM_AW-1:0] addr;
        logic [31:0]        word;
    } load_t;

    typedef struct packed {
        logic        is_store;
        logic [7:0]  test;
        logic [31:0] addr;
        logic [31:0] data;
    } event_t;

    logic               clk = 1'b0;
    logic               reset_i;
    logic               run_i;
    logic               imem_we_i;
    logic [IMEM_AW-1:0] imem_addr_i;
    logic [31:0]        imem_data_i;
    retire_t            retire_o;

    load_t       load_q[$];
    event_t      expect_q[$];
    int          next_event = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_done = 0;
    int          cycles = 0;
    int          limit = 0;
    logic        checking = 1'b0;
    logic [31:0] prev_pc = '0;
    logic        prev_seen = 1'b0;

    mips_core UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .run_i       (run_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .retire_o    (retire_o)
    );

    always #5 clk = ~clk;

    task automatic read_stim();
        int            fd;
        int            n;
        int            test_num;
        logic [7:0]    tag;
        logic [31:0]   a;
        logic [31:0]   d;
        logic [1023:0] rest;
        test_num = 0;
        fd = $fopen("sim/mips_core_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stim file sim/mips_core_stim.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": n = $fgets(rest, fd);
                "T": n = $fscanf(fd, "%d", test_num);
                "I": begin
                    n = $fscanf(fd, "%d %h", a, d);
                    load_q.push_back('{addr: a[IMEM_AW-1:0], word: d});
                end
                "R": begin
                    n = $fscanf(fd, "%d %h", a, d);
                    expect_q.push_back('{is_store: 1'b0, test: test_num[7:0], addr: a, data: d});
                end
                "S": begin
                    n = $fscanf(fd, "%h %h", a, d);
                    expect_q.push_back('{is_store: 1'b1, test: test_num[7:0], addr: a, data: d});
                end
                default: begin
                    $display("the stim file holds a line of unknown type %c", tag);
                    errors++;
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic check_reg_write(input retire_t got, input logic [4:0] exp_addr,
                                   input logic [31:0] exp_data);
        if (got.rf_we !== 1'b1 || got.rf_addr !== exp_addr || got.rf_data !== exp_data) begin
            $display("** Error at %0t: pc %h expected r%0d = %h, got rf_we %b r%0d = %h",
                     $time, got.pc, exp_addr, exp_data, got.rf_we, got.rf_addr, got.rf_data);
            errors++;
        end
    endtask

    task automatic check_store(input retire_t got, input logic [31:0] exp_addr,
                               input logic [31:0] exp_data);
        if (got.mem_we !== 1'b1 || got.mem_addr !== exp_addr || got.mem_data !== exp_data) begin
            $display("** Error at %0t: pc %h expected store %h to %h, got mem_we %b %h to %h",
                     $time, got.pc, exp_data, exp_addr, got.mem_we, got.mem_data, got.mem_addr);
            errors++;
        end
    endtask

    // the program only branches forward, so each event sits at a loaded word past the last.
    task automatic check_pc(input retire_t got);
        logic in_program;
        in_program = 1'b0;
        foreach (load_q[i]) begin
            if ({{(30-IMEM_AW){1'b0}}, load_q[i].addr, 2'b00} === got.pc) begin
                in_program = 1'b1;
            end
        end
        if (!in_program || (prev_seen && got.pc <= prev_pc)) begin
            $display("** Error at %0t: pc %h is not a loaded word after pc %h",
                     $time, got.pc, prev_pc);
            errors++;
        end
        prev_pc   = got.pc;
        prev_seen = 1'b1;
    endtask

    task automatic take_event(input retire_t got);
        event_t exp;
        int     errors_before;
        if (next_event >= expect_q.size()) begin
            $display("a write event at pc %h came after the last expected one", got.pc);
            errors++;
            return;
        end
        exp = expect_q[next_event];
        errors_before = errors;
        if (exp.is_store) begin
            check_store(got, exp.addr, exp.data);
        end else begin
            check_reg_write(got, exp.addr[4:0], exp.data);
        end
        check_pc(got);
        test_errors += errors - errors_before;
        next_event++;
        if (next_event == expect_q.size() || expect_q[next_event].test != exp.test) begin
            $display("test %0d %s with %0d errors", exp.test,
                     (test_errors == 0) ? "passed" : "failed", test_errors);
            tests_done++;
            test_errors = 0;
        end
    endtask

    // the record is combinational, so at the edge it still shows the retiring instruction.
    always @(posedge clk) begin
        if (checking && retire_o.valid && (retire_o.rf_we || retire_o.mem_we)) begin
            take_event(retire_o);
        end
    end

    initial begin
        logic [31:0] seed_init;
        reset_i     = 1'b1;
        run_i       = 1'b0;
        imem_we_i   = 1'b0;
        imem_addr_i = '0;
        imem_data_i = '0;
        seed_init   = $urandom(9);
        read_stim();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        foreach (load_q[i]) begin
            imem_we_i   = 1'b1;
            imem_addr_i = load_q[i].addr;
            imem_data_i = load_q[i].word;
            @(negedge clk);
        end
        imem_we_i = 1'b0;
        limit     = 4 * load_q.size() + 100;
        checking  = 1'b1;
        while (next_event < expect_q.size() && cycles < limit) begin
            run_i = ($urandom % 4) != 0;  // roughly one paused cycle in four.
            @(negedge clk);
            cycles++;
        end
        if (next_event < expect_q.size()) begin
            $display("timeout after %0d cycles, %0d of %0d expected events were never observed",
                     cycles, expect_q.size() - next_event, expect_q.size());
            errors++;
        end
        run_i = 1'b1;  // the final self-jump must stay silent.
        repeat (8) @(negedge clk);
        run_i = 1'b0;
        $display("%0d tests finished, %0d of %0d events checked, %0d errors",
                 tests_done, next_event, expect_q.size(), errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
